//--- project.f
verilog/hsst_line_pkg.sv
verilog/hsst_cfg_pkg.sv
verilog/tx_word_fifo.sv
verilog/tx_lane_framer.sv
verilog/tx_lane_cfg_regs.sv
verilog/hsst_tx_src.sv
verif/hsst_tx_src_asserts.sv
verif/tb_hsst_tx_src.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/100ps \
    --top-module tb_hsst_tx_src -f project.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }

//--- verif/tb_hsst_tx_src.sv
module tb_hsst_tx_src
    import hsst_line_pkg::*;
    import hsst_cfg_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_ROWS = 7;

    typedef struct packed {
        int   lane;
        int   gap;
        int   level;
        int   nwords;
        logic prefill;    // fill the fifo before the lane is enabled.
    } row_t;

    logic                   src_clk;
    logic                   i_src_rstn;
    logic     [N_LANES-1:0] i_wr_en;
    payload_t [N_LANES-1:0] i_wr_data;
    logic     [N_LANES-1:0] o_full;
    logic                   i_cfg_wr;
    cfg_addr_t              i_cfg_addr;
    cfg_data_t              i_cfg_wdata;
    cfg_data_t              o_cfg_rdata;
    lane_tx_t [N_LANES-1:0] o_tx;

    row_t        rows [N_ROWS];
    string       row_name [N_ROWS];
    string       cur_name;
    logic [15:0] lfsr;
    payload_t    exp_q [N_LANES][$];   // pushed, not yet seen on the line.
    int          seen [N_LANES];
    int          last_cyc [N_LANES];
    logic        have_last [N_LANES];
    logic        spacing_on [N_LANES];
    int          spacing_gap [N_LANES];
    logic        mon_on;
    int          cyc;
    int          value_errs;
    int          other_errs;

    hsst_tx_src u_hsst_tx_src (
        .src_clk     (src_clk),
        .i_src_rstn  (i_src_rstn),
        .i_wr_en     (i_wr_en),
        .i_wr_data   (i_wr_data),
        .o_full      (o_full),
        .i_cfg_wr    (i_cfg_wr),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .o_cfg_rdata (o_cfg_rdata),
        .o_tx        (o_tx)
    );

    always #2 src_clk = ~src_clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // one lfsr step per payload bit.
    function automatic payload_t next_payload();
        payload_t w;
        int       b;
        w = '0;
        for (b = 0; b < 32; b++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    // line monitor on the falling edge, where o_tx is stable.
    always @(negedge src_clk) begin
        lane_tx_t tx;
        payload_t exp_w;
        int       delta;
        int       l;
        cyc++;
        if (mon_on) begin
            for (l = 0; l < N_LANES; l++) begin
                tx = o_tx[l];
                if (tx.txk == '0) begin
                    assert (exp_q[l].size() != 0) else begin
                        other_errs++;
                        $display("%s: lane %0d sent data 0x%h with no word queued",
                                 cur_name, l, tx.txd);
                    end
                    if (exp_q[l].size() != 0) begin
                        exp_w = exp_q[l].pop_front();
                        assert (tx.txd == {8'h00, exp_w}) else begin
                            value_errs++;
                            $display("ERR %s: lane %0d data expected 0x%h actual 0x%h",
                                     cur_name, l, {8'h00, exp_w}, tx.txd);
                        end
                    end
                    if (spacing_on[l] && have_last[l]) begin
                        delta = cyc - last_cyc[l];
                        assert (delta == spacing_gap[l] + 1) else begin
                            value_errs++;
                            $display("ERR %s: lane %0d spacing expected %0d actual %0d",
                                     cur_name, l, spacing_gap[l] + 1, delta);
                        end
                    end
                    last_cyc[l]  = cyc;
                    have_last[l] = 1'b1;
                    seen[l]++;
                end else begin
                    assert (tx.txk == IDLE_TXK && tx.txd == IDLE_TXD) else begin
                        value_errs++;
                        $display("ERR %s: lane %0d idle expected %h_%h actual %h_%h",
                                 cur_name, l, IDLE_TXK, IDLE_TXD, tx.txk, tx.txd);
                    end
                end
            end
        end
    end

    task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
        @(posedge src_clk);
        i_cfg_wr    <= 1'b1;
        i_cfg_addr  <= addr;
        i_cfg_wdata <= data;
        @(posedge src_clk);
        i_cfg_wr    <= 1'b0;
    endtask

    task automatic read_reg(input cfg_addr_t addr, output cfg_data_t data);
        @(posedge src_clk);
        i_cfg_addr <= addr;
        @(negedge src_clk);
        data = o_cfg_rdata;   // read mux is combinational.
    endtask

    task automatic push_words(input int lane, input int n);
        payload_t w;
        int       i;
        for (i = 0; i < n; i++) begin
            @(posedge src_clk);
            w = next_payload();
            i_wr_en[lane]   <= 1'b1;
            i_wr_data[lane] <= w;
            exp_q[lane].push_back(w);
        end
        @(posedge src_clk);
        i_wr_en[lane] <= 1'b0;
    endtask

    task automatic wait_for_data(input int lane, input int target, input int limit);
        int waited;
        waited = 0;
        while (seen[lane] < target && waited < limit) begin
            @(posedge src_clk);
            waited++;
        end
        assert (seen[lane] >= target) else begin
            other_errs++;
            $display("%s: timeout waiting for lane output on lane %0d", cur_name, lane);
        end
    endtask

    task automatic wait_for_full(input int lane, input int limit);
        int waited;
        waited = 0;
        @(negedge src_clk);
        while (!o_full[lane] && waited < limit) begin
            @(negedge src_clk);
            waited++;
        end
        assert (o_full[lane]) else begin
            other_errs++;
            $display("%s: timeout waiting for the full flag on lane %0d", cur_name, lane);
        end
    endtask

    task automatic compare_sent(input int lane);
        cfg_data_t rd;
        read_reg(lane == 0 ? ADDR_SENT0 : ADDR_SENT1, rd);
        assert (rd == cfg_data_t'(seen[lane])) else begin
            value_errs++;
            $display("ERR %s: lane %0d sent count expected %0d actual %0d",
                     cur_name, lane, cfg_data_t'(seen[lane]), rd);
        end
    endtask

    task automatic verify_reset();
        cfg_data_t rd;
        int        a;
        cur_name = "reset_state";
        @(negedge src_clk);
        assert (o_full == '0) else begin
            value_errs++;
            $display("ERR %s: o_full expected 00 actual %b", cur_name, o_full);
        end
        for (a = 0; a <= 5; a++) begin
            read_reg(cfg_addr_t'(a), rd);
            assert (rd == '0) else begin
                value_errs++;
                $display("ERR %s: reg %0d expected 0x0000 actual 0x%h", cur_name, a, rd);
            end
        end
    endtask

    task automatic run_row(input int r);
        int lane;
        int g;
        int lv;
        int n;
        int base;
        int limit;
        lane     = rows[r].lane;
        g        = rows[r].gap;
        lv       = rows[r].level;
        n        = rows[r].nwords;
        cur_name = row_name[r];
        limit    = (g + 1) * n + 64;
        write_reg(ADDR_LANE_EN, '0);
        write_reg(lane == 0 ? ADDR_GAP0 : ADDR_GAP1, cfg_data_t'(g));
        write_reg(ADDR_AE_LEVEL, cfg_data_t'(lv));
        base              = seen[lane];
        have_last[lane]   = 1'b0;
        spacing_gap[lane] = g;
        spacing_on[lane]  = rows[r].prefill;
        if (rows[r].prefill) begin
            push_words(lane, n);
            write_reg(ADDR_LANE_EN, cfg_data_t'(1) << lane);
        end else begin
            write_reg(ADDR_LANE_EN, cfg_data_t'(1) << lane);
            push_words(lane, n);
        end
        wait_for_data(lane, base + n - lv, limit);
        spacing_on[lane] = 1'b0;
        repeat ((g + 1) * 4 + 8) @(posedge src_clk);    // held-back words must stay put.
        assert (seen[lane] == base + n - lv) else begin
            value_errs++;
            $display("ERR %s: data words expected %0d actual %0d",
                     cur_name, n - lv, seen[lane] - base);
        end
        assert (exp_q[lane].size() == lv) else begin
            value_errs++;
            $display("ERR %s: held words expected %0d actual %0d",
                     cur_name, lv, exp_q[lane].size());
        end
        if (lv > 0) begin
            write_reg(ADDR_AE_LEVEL, '0);   // release the rest.
            wait_for_data(lane, base + n, limit);
        end
        compare_sent(lane);
        write_reg(ADDR_LANE_EN, '0);
    endtask

    task automatic lane_isolation();
        int held;
        int base1;
        cur_name = "lane_isolation";
        write_reg(ADDR_LANE_EN, '0);
        write_reg(ADDR_AE_LEVEL, '0);
        write_reg(ADDR_GAP0, '0);
        write_reg(ADDR_GAP1, 16'd2);
        push_words(0, FIFO_DEPTH - 1);
        @(negedge src_clk);
        assert (!o_full[0]) else begin
            other_errs++;
            $display("%s: lane 0 full flag high one word early", cur_name);
        end
        push_words(0, 1);
        wait_for_full(0, 4);
        @(posedge src_clk);
        i_wr_en[0]   <= 1'b1;   // dropped, so it is never queued.
        i_wr_data[0] <= 32'hDEAD_BEEF;
        @(posedge src_clk);
        i_wr_en[0]   <= 1'b0;
        held = seen[0];
        write_reg(ADDR_LANE_EN, 16'h0002);
        base1 = seen[1];
        push_words(1, 6);
        wait_for_data(1, base1 + 6, 3 * 6 + 64);
        repeat (8) @(posedge src_clk);
        assert (seen[0] == held && o_full[0]) else begin
            other_errs++;
            $display("%s: disabled lane 0 sent data or lost its fifo contents", cur_name);
        end
        write_reg(ADDR_LANE_EN, 16'h0001);
        wait_for_data(0, held + FIFO_DEPTH, FIFO_DEPTH + 64);
        repeat (8) @(posedge src_clk);
        compare_sent(0);
        compare_sent(1);
        write_reg(ADDR_LANE_EN, '0);
    endtask

    initial begin
        int r;
        int l;
        src_clk     = 1'b0;
        i_src_rstn  <= 1'b0;
        i_wr_en     <= '0;
        i_wr_data   <= '0;
        i_cfg_wr    <= 1'b0;
        i_cfg_addr  <= '0;
        i_cfg_wdata <= '0;
        lfsr        = 16'd14402;
        mon_on      = 1'b0;
        cyc         = 0;
        value_errs  = 0;
        other_errs  = 0;
        cur_name    = "reset_state";
        for (l = 0; l < N_LANES; l++) begin
            seen[l]        = 0;
            last_cyc[l]    = 0;
            have_last[l]   = 1'b0;
            spacing_on[l]  = 1'b0;
            spacing_gap[l] = 0;
        end

        // lane, gap, level, words, prefill.
        row_name[0] = "gap0_fill";
        rows[0]     = '{0, 0, 0, 12, 1'b1};
        row_name[1] = "gap7_fill";
        rows[1]     = '{1, 7, 0, 8, 1'b1};
        row_name[2] = "gap3_hold";
        rows[2]     = '{0, 3, 4, 10, 1'b1};
        row_name[3] = "gap0_stream";
        rows[3]     = '{1, 0, 3, 16, 1'b0};
        row_name[4] = "gap7_stream";
        rows[4]     = '{0, 7, 2, 9, 1'b0};
        row_name[5] = "gap1_hold";
        rows[5]     = '{1, 1, 6, 14, 1'b1};
        row_name[6] = "gap15_fill";
        rows[6]     = '{0, 15, 1, 5, 1'b1};

        repeat (10) @(posedge src_clk);
        i_src_rstn <= 1'b1;
        @(posedge src_clk);
        mon_on = 1'b1;

        verify_reset();
        for (r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        lane_isolation();

        $display("tb_hsst_tx_src: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verif/hsst_tx_src_asserts.sv
module hsst_tx_src_asserts
    import hsst_line_pkg::*;
    import hsst_cfg_pkg::*;
(
    input logic      src_clk,
    input logic      i_src_rstn,
    input lane_cfg_t i_lane_cfg,
    input logic      i_almost_empty,
    input logic      i_rd_en,
    input lane_tx_t  i_tx
);

    timeunit 1ns;
    timeprecision 100ps;

    gap_t idle_left;  // idle words still owed after the last data word.

    always_ff @(posedge src_clk) begin
        if (!i_src_rstn) begin
            idle_left <= '0;
        end else if (i_tx.txk == '0) begin
            idle_left <= i_lane_cfg.gap;
        end else if (idle_left != '0) begin
            idle_left <= idle_left - 1'b1;
        end
    end

    // every data word on the line follows a pop made while enabled and not almost empty.
    pop_allowed: assert property (@(posedge src_clk) disable iff (!i_src_rstn)
        (i_tx.txk == '0) |-> $past(i_rd_en && i_lane_cfg.en && !i_almost_empty))
        else $error("data word sent without a pop while enabled and not almost empty");

    idle_is_comma: assert property (@(posedge src_clk) disable iff (!i_src_rstn)
        (i_tx.txk != '0) |-> (i_tx.txk == IDLE_TXK && i_tx.txd == IDLE_TXD))
        else $error("non-data word is not the comma idle");

    gap_respected: assert property (@(posedge src_clk) disable iff (!i_src_rstn)
        (idle_left != '0) |-> (i_tx.txk == IDLE_TXK))
        else $error("data word sent inside the idle gap");

endmodule

// one checker per lane framer.
bind tx_lane_framer hsst_tx_src_asserts u_framer_asserts (
    .src_clk        (src_clk),
    .i_src_rstn     (i_src_rstn),
    .i_lane_cfg     (i_lane_cfg),
    .i_almost_empty (i_almost_empty),
    .i_rd_en        (o_rd_en),
    .i_tx           (o_tx)
);

//--- verilog/hsst_tx_src.sv
module hsst_tx_src
    import hsst_line_pkg::*;
    import hsst_cfg_pkg::*;
(
    input  logic                    src_clk,
    input  logic                    i_src_rstn,
    input  logic     [N_LANES-1:0]  i_wr_en,
    input  payload_t [N_LANES-1:0]  i_wr_data,
    output logic     [N_LANES-1:0]  o_full,
    input  logic                    i_cfg_wr,
    input  cfg_addr_t               i_cfg_addr,
    input  cfg_data_t               i_cfg_wdata,
    output cfg_data_t               o_cfg_rdata,
    output lane_tx_t [N_LANES-1:0]  o_tx
);

    lane_cfg_t [N_LANES-1:0] lane_cfg;
    sent_cnt_t [N_LANES-1:0] sent_cnt;
    fill_t                   ae_level;  // one level for every lane.

    tx_lane_cfg_regs u_cfg_regs (
        .src_clk     (src_clk),
        .i_src_rstn  (i_src_rstn),
        .i_cfg_wr    (i_cfg_wr),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .o_cfg_rdata (o_cfg_rdata),
        .i_sent_cnt  (sent_cnt),
        .o_lane_cfg  (lane_cfg),
        .o_ae_level  (ae_level)
    );

    for (genvar n = 0; n < N_LANES; n++) begin : g_lane
        logic     rd_en;
        logic     almost_empty;
        payload_t rd_data;

        tx_word_fifo u_fifo (
            .src_clk        (src_clk),
            .i_src_rstn     (i_src_rstn),
            .i_wr_en        (i_wr_en[n]),
            .i_wr_data      (i_wr_data[n]),
            .i_rd_en        (rd_en),
            .o_rd_data      (rd_data),
            .i_ae_level     (ae_level),
            .o_full         (o_full[n]),
            .o_almost_empty (almost_empty)
        );

        // push to line is two cycles, one in the fifo and one here.
        tx_lane_framer u_framer (
            .src_clk        (src_clk),
            .i_src_rstn     (i_src_rstn),
            .i_lane_cfg     (lane_cfg[n]),
            .i_almost_empty (almost_empty),
            .i_rd_data      (rd_data),
            .o_rd_en        (rd_en),
            .o_tx           (o_tx[n]),
            .o_sent_cnt     (sent_cnt[n])
        );
    end

endmodule

//--- verilog/tx_lane_cfg_regs.sv
module tx_lane_cfg_regs
    import hsst_line_pkg::*;
    import hsst_cfg_pkg::*;
(
    input  logic                       src_clk,
    input  logic                       i_src_rstn,
    input  logic                       i_cfg_wr,
    input  cfg_addr_t                  i_cfg_addr,
    input  cfg_data_t                  i_cfg_wdata,
    output cfg_data_t                  o_cfg_rdata,
    input  sent_cnt_t [N_LANES-1:0]    i_sent_cnt,
    output lane_cfg_t [N_LANES-1:0]    o_lane_cfg,
    output fill_t                      o_ae_level
);

    logic [N_LANES-1:0] lane_en;
    gap_t [N_LANES-1:0] gap_q;
    fill_t              ae_level;

    always_ff @(posedge src_clk) begin
        if (!i_src_rstn) begin
            lane_en  <= '0;
            gap_q    <= '0;
            ae_level <= '0;
        end else if (i_cfg_wr) begin
            case (i_cfg_addr)
                ADDR_LANE_EN:  lane_en  <= i_cfg_wdata[N_LANES-1:0];
                ADDR_GAP0:     gap_q[0] <= i_cfg_wdata[$bits(gap_t)-1:0];
                ADDR_GAP1:     gap_q[1] <= i_cfg_wdata[$bits(gap_t)-1:0];
                ADDR_AE_LEVEL: ae_level <= i_cfg_wdata[$bits(fill_t)-1:0];
                default:       ;  // counters and unmapped are read only.
            endcase
        end
    end

    always_comb begin
        case (i_cfg_addr)
            ADDR_LANE_EN:  o_cfg_rdata = cfg_data_t'(lane_en);
            ADDR_GAP0:     o_cfg_rdata = cfg_data_t'(gap_q[0]);
            ADDR_GAP1:     o_cfg_rdata = cfg_data_t'(gap_q[1]);
            ADDR_AE_LEVEL: o_cfg_rdata = cfg_data_t'(ae_level);
            ADDR_SENT0:    o_cfg_rdata = cfg_data_t'(i_sent_cnt[0]);
            ADDR_SENT1:    o_cfg_rdata = cfg_data_t'(i_sent_cnt[1]);
            default:       o_cfg_rdata = '0;
        endcase
    end

    always_comb begin
        for (int n = 0; n < N_LANES; n++) begin
            o_lane_cfg[n].en  = lane_en[n];
            o_lane_cfg[n].gap = gap_q[n];
        end
    end

    assign o_ae_level = ae_level;

endmodule

//--- verilog/tx_lane_framer.sv
module tx_lane_framer
    import hsst_line_pkg::*;
    import hsst_cfg_pkg::*;
(
    input  logic      src_clk,
    input  logic      i_src_rstn,
    input  lane_cfg_t i_lane_cfg,
    input  logic      i_almost_empty,
    input  payload_t  i_rd_data,
    output logic      o_rd_en,
    output lane_tx_t  o_tx,
    output sent_cnt_t o_sent_cnt
);

    gap_t gap_cnt;    // idle slots since the last data word.
    logic data_slot;

    // a gap lowered mid-run still counts as reached.
    assign data_slot = i_lane_cfg.en
                    && (gap_cnt >= i_lane_cfg.gap)
                    && !i_almost_empty;

    assign o_rd_en = data_slot;  // fifo pops at the same edge.

    always_ff @(posedge src_clk) begin
        if (!i_src_rstn) begin
            o_tx.txd   <= IDLE_TXD;
            o_tx.txk   <= IDLE_TXK;
            gap_cnt    <= '0;
            o_sent_cnt <= '0;
        end else if (data_slot) begin
            o_tx.txd   <= {8'h00, i_rd_data};
            o_tx.txk   <= '0;
            gap_cnt    <= '0;
            o_sent_cnt <= o_sent_cnt + 1'b1;  // wraps at 16 bits.
        end else begin
            o_tx.txd <= IDLE_TXD;
            o_tx.txk <= IDLE_TXK;
            if (gap_cnt < i_lane_cfg.gap) begin
                gap_cnt <= gap_cnt + 1'b1;
            end else begin
                gap_cnt <= i_lane_cfg.gap;    // saturate.
            end
        end
    end

endmodule

//--- verilog/tx_word_fifo.sv
module tx_word_fifo
    import hsst_line_pkg::*;
(
    input  logic     src_clk,
    input  logic     i_src_rstn,
    input  logic     i_wr_en,
    input  payload_t i_wr_data,
    input  logic     i_rd_en,
    output payload_t o_rd_data,
    input  fill_t    i_ae_level,
    output logic     o_full,
    output logic     o_almost_empty
);

    payload_t           mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    fill_t              count;
    logic               push;
    logic               pop;

    assign push = i_wr_en && !o_full;      // writes into a full fifo are dropped.
    assign pop  = i_rd_en && (count != '0);

    always_ff @(posedge src_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge src_clk) begin
        if (!i_src_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither.
            endcase
        end
    end

    // show-ahead head word.
    assign o_rd_data = mem[rd_ptr];

    assign o_full         = (count == fill_t'(FIFO_DEPTH));
    assign o_almost_empty = (count <= i_ae_level);  // always high when empty.

endmodule

//--- verilog/hsst_cfg_pkg.sv
package hsst_cfg_pkg;

    typedef logic [3:0]  cfg_addr_t;
    typedef logic [15:0] cfg_data_t;
    typedef logic [3:0]  gap_t;        // idle words after each data word.

    typedef struct packed {
        logic en;
        gap_t gap;
    } lane_cfg_t;

    // register map.
    localparam cfg_addr_t ADDR_LANE_EN  = 4'd0;  // bit n enables lane n.
    localparam cfg_addr_t ADDR_GAP0     = 4'd1;
    localparam cfg_addr_t ADDR_GAP1     = 4'd2;
    localparam cfg_addr_t ADDR_AE_LEVEL = 4'd3;  // shared by all lanes.
    localparam cfg_addr_t ADDR_SENT0    = 4'd4;  // read only.
    localparam cfg_addr_t ADDR_SENT1    = 4'd5;  // read only.

endpackage

//--- verilog/hsst_line_pkg.sv
package hsst_line_pkg;

    localparam int N_LANES    = 2;
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;

    typedef logic [31:0] payload_t;    // word from the write side.
    typedef logic [39:0] txd_t;        // 40-bit line word.
    typedef logic [3:0]  txk_t;        // one k flag per byte.
    typedef logic [4:0]  fill_t;       // 0 to FIFO_DEPTH.
    typedef logic [15:0] sent_cnt_t;

    // comma idle, K28.5 in bytes 0 and 2.
    localparam txd_t IDLE_TXD = 40'h00_50BC_50BC;
    localparam txk_t IDLE_TXK = 4'b0101;

    typedef struct packed {
        txk_t txk;
        txd_t txd;
    } lane_tx_t;

endpackage
